/* hdl/eth_tx_params.svh */
// eth_tx parameters: stream widths and Ethernet frame length limits
`ifndef ETH_TX_PARAMS_SVH
`define ETH_TX_PARAMS_SVH

// stream data width in bits
`define ETH_DATA_W 64

// one keep bit per data byte
`define ETH_KEEP_W 8

// destination MAC, source MAC and ethertype
`define ETH_HDR_BYTES 14

// shortest legal frame, FCS not counted
`define ETH_MIN_BYTES 60

`endif

/* hdl/eth_pkg.sv */
// Ethernet header field types and the transmit state encodings
package eth_pkg;

    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] ethertype_t;

    // byte position within one frame
    typedef logic [7:0] byte_count_t;

    // framer states
    typedef enum logic [1:0] {
        idle,
        write_header,
        write_header_last,
        write_payload
    } tx_state_t;

    // padder states
    typedef enum logic {
        pass,
        fill
    } pad_state_t;

endpackage

/* hdl/axis_pkg.sv */
// Stream word types for the 64-bit transmit datapath
`include "eth_tx_params.svh"

package axis_pkg;

    // byte 0 sits in the low lane
    typedef logic [`ETH_DATA_W-1:0] axis_data_t;

    // contiguous from lane 0
    typedef logic [`ETH_KEEP_W-1:0] axis_keep_t;

endpackage

/* hdl/axis_out_buffer.sv */
// Stream output stage: output register plus spare register, full rate under back-pressure
module axis_out_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_data_t in_tdata,
    input  axis_pkg::axis_keep_t in_tkeep,
    input  logic                 in_tvalid,
    input  logic                 in_tlast,
    input  logic                 in_tuser,
    output logic                 in_tready_early,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep,
    output logic                 out_tvalid,
    output logic                 out_tlast,
    output logic                 out_tuser,
    input  logic                 out_tready
);

    axis_pkg::axis_data_t temp_tdata;
    axis_pkg::axis_keep_t temp_tkeep;
    logic                 temp_tvalid;
    logic                 temp_tlast;
    logic                 temp_tuser;

    // ready next cycle if the sink drains, both slots are empty,
    // or the spare slot is empty and stays empty this cycle
    assign in_tready_early = out_tready || (!temp_tvalid && !out_tvalid) ||
                             (!temp_tvalid && !in_tvalid);

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid  <= 1'b0;
            temp_tvalid <= 1'b0;
        end else if (in_tvalid) begin
            if (out_tready || !out_tvalid) begin
                out_tvalid <= 1'b1;
            end else begin
                temp_tvalid <= 1'b1;
            end
        end else if (out_tready) begin
            // spare word moves up, or the output empties
            out_tvalid  <= temp_tvalid;
            temp_tvalid <= 1'b0;
        end
    end

    // word contents
    always_ff @(posedge clk) begin
        if (in_tvalid) begin
            if (out_tready || !out_tvalid) begin
                out_tdata <= in_tdata;
                out_tkeep <= in_tkeep;
                out_tlast <= in_tlast;
                out_tuser <= in_tuser;
            end else begin
                // word in flight during a stall
                temp_tdata <= in_tdata;
                temp_tkeep <= in_tkeep;
                temp_tlast <= in_tlast;
                temp_tuser <= in_tuser;
            end
        end else if (out_tready) begin
            out_tdata <= temp_tdata;
            out_tkeep <= temp_tkeep;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end
    end

endmodule

/* hdl/eth_axis_tx.sv */
// Ethernet transmit framer: parallel header fields and payload stream merged into one stream
`include "eth_tx_params.svh"

module eth_axis_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hdr_valid,
    output logic                 hdr_ready,
    input  eth_pkg::mac_addr_t   dest_mac,
    input  eth_pkg::mac_addr_t   src_mac,
    input  eth_pkg::ethertype_t  eth_type,
    input  axis_pkg::axis_data_t payload_tdata,
    input  axis_pkg::axis_keep_t payload_tkeep,
    input  logic                 payload_tvalid,
    input  logic                 payload_tlast,
    input  logic                 payload_tuser,
    output logic                 payload_tready,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep,
    output logic                 out_tvalid,
    output logic                 out_tlast,
    output logic                 out_tuser,
    input  logic                 out_tready,
    output logic                 busy
);

    // header lanes of the second output word
    localparam axis_pkg::axis_keep_t HDR_TAIL_KEEP =
        axis_pkg::axis_keep_t'((1 << (`ETH_HDR_BYTES - `ETH_KEEP_W)) - 1);

    eth_pkg::tx_state_t   state;
    eth_pkg::tx_state_t   state_next;
    logic                 hdr_ready_next;
    logic                 payload_tready_next;
    logic                 store_hdr;
    logic                 flush_save;
    logic                 load_save;
    logic                 buf_ready;
    logic                 buf_ready_early;
    eth_pkg::mac_addr_t   dest_mac_reg;
    eth_pkg::mac_addr_t   src_mac_reg;
    eth_pkg::ethertype_t  eth_type_reg;
    axis_pkg::axis_data_t save_tdata;
    axis_pkg::axis_keep_t save_tkeep;
    logic                 save_tlast;
    logic                 save_tuser;
    logic                 extra;
    axis_pkg::axis_data_t shift_tdata;
    axis_pkg::axis_keep_t shift_tkeep;
    logic                 shift_tlast;
    logic                 shift_tuser;
    logic                 shift_fire;
    logic                 last_in;
    axis_pkg::axis_data_t buf_tdata;
    axis_pkg::axis_keep_t buf_tkeep;
    logic                 buf_tvalid;
    logic                 buf_tlast;
    logic                 buf_tuser;

    // both MACs go out most significant byte first
    function automatic axis_pkg::axis_data_t first_word(eth_pkg::mac_addr_t dst,
                                                       eth_pkg::mac_addr_t src);
        return {src[39:32], src[47:40], dst[7:0], dst[15:8],
                dst[23:16], dst[31:24], dst[39:32], dst[47:40]};
    endfunction

    // saved word still holds bytes after the six-lane shift
    assign extra = save_tlast && (save_tkeep[7:2] != '0);

    assign shift_tdata = {extra ? 16'h0000 : payload_tdata[15:0], save_tdata[63:16]};
    assign shift_tkeep = {extra ? 2'b00 : payload_tkeep[1:0], save_tkeep[7:2]};
    assign shift_tlast = extra ? 1'b1 : payload_tlast && (payload_tkeep[7:2] == '0);
    assign shift_tuser = extra ? save_tuser : payload_tuser && shift_tlast;

    // flush word needs only buffer space, otherwise an input word must arrive
    assign shift_fire = extra ? buf_ready : payload_tready && payload_tvalid;
    assign last_in    = payload_tready && payload_tvalid && payload_tlast;

    always_comb begin
        state_next          = state;
        hdr_ready_next      = 1'b0;
        payload_tready_next = 1'b0;
        store_hdr           = 1'b0;
        flush_save          = 1'b0;
        load_save           = 1'b0;
        buf_tdata           = '0;
        buf_tkeep           = '0;
        buf_tvalid          = 1'b0;
        buf_tlast           = 1'b0;
        buf_tuser           = 1'b0;

        case (state)
            eth_pkg::idle: begin
                flush_save     = 1'b1;
                hdr_ready_next = 1'b1;
                if (hdr_ready && hdr_valid) begin
                    store_hdr      = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next     = eth_pkg::write_header;
                    // word 0 straight from the header inputs when there is room
                    if (buf_ready) begin
                        buf_tdata           = first_word(dest_mac, src_mac);
                        buf_tkeep           = '1;
                        buf_tvalid          = 1'b1;
                        payload_tready_next = buf_ready_early;
                        state_next          = eth_pkg::write_header_last;
                    end
                end
            end
            eth_pkg::write_header: begin
                if (buf_ready) begin
                    buf_tdata           = first_word(dest_mac_reg, src_mac_reg);
                    buf_tkeep           = '1;
                    buf_tvalid          = 1'b1;
                    payload_tready_next = buf_ready_early;
                    state_next          = eth_pkg::write_header_last;
                end
            end
            eth_pkg::write_header_last: begin
                payload_tready_next = buf_ready_early && !last_in;
                if (shift_fire) begin
                    // header tail plus first two payload bytes
                    buf_tdata  = {shift_tdata[63:48], eth_type_reg[7:0], eth_type_reg[15:8],
                                  src_mac_reg[7:0], src_mac_reg[15:8],
                                  src_mac_reg[23:16], src_mac_reg[31:24]};
                    buf_tkeep  = shift_tkeep | HDR_TAIL_KEEP;
                    buf_tvalid = 1'b1;
                    buf_tlast  = shift_tlast;
                    buf_tuser  = shift_tuser;
                    load_save  = 1'b1;
                    state_next = eth_pkg::write_payload;
                    if (shift_tlast) begin
                        payload_tready_next = 1'b0;
                        flush_save          = 1'b1;
                        hdr_ready_next      = 1'b1;
                        state_next          = eth_pkg::idle;
                    end
                end
            end
            eth_pkg::write_payload: begin
                payload_tready_next = buf_ready_early && !extra && !last_in;
                if (shift_fire) begin
                    buf_tdata  = shift_tdata;
                    buf_tkeep  = shift_tkeep;
                    buf_tvalid = 1'b1;
                    buf_tlast  = shift_tlast;
                    buf_tuser  = shift_tuser;
                    load_save  = 1'b1;
                    if (shift_tlast) begin
                        payload_tready_next = 1'b0;
                        flush_save          = 1'b1;
                        hdr_ready_next      = 1'b1;
                        state_next          = eth_pkg::idle;
                    end
                end
            end
            default: state_next = eth_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= eth_pkg::idle;
            hdr_ready      <= 1'b0;
            payload_tready <= 1'b0;
            buf_ready      <= 1'b0;
            busy           <= 1'b0;
            save_tkeep     <= '0;
            save_tlast     <= 1'b0;
        end else begin
            state          <= state_next;
            hdr_ready      <= hdr_ready_next;
            payload_tready <= payload_tready_next;
            buf_ready      <= buf_ready_early;
            busy           <= state_next != eth_pkg::idle;
            if (flush_save) begin
                save_tkeep <= '0;
                save_tlast <= 1'b0;
            end else if (load_save) begin
                save_tkeep <= payload_tkeep;
                save_tlast <= payload_tlast;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            dest_mac_reg <= dest_mac;
            src_mac_reg  <= src_mac;
            eth_type_reg <= eth_type;
        end
        if (flush_save) begin
            save_tdata <= '0;
            save_tuser <= 1'b0;
        end else if (load_save) begin
            save_tdata <= payload_tdata;
            save_tuser <= payload_tuser;
        end
    end

    axis_out_buffer i_axis_out_buffer (
        .clk             (clk),
        .rst             (rst),
        .in_tdata        (buf_tdata),
        .in_tkeep        (buf_tkeep),
        .in_tvalid       (buf_tvalid),
        .in_tlast        (buf_tlast),
        .in_tuser        (buf_tuser),
        .in_tready_early (buf_ready_early),
        .out_tdata       (out_tdata),
        .out_tkeep       (out_tkeep),
        .out_tvalid      (out_tvalid),
        .out_tlast       (out_tlast),
        .out_tuser       (out_tuser),
        .out_tready      (out_tready)
    );

endmodule

/* hdl/eth_frame_pad.sv */
// Ethernet minimum-length padder: zero-fills frames shorter than 60 bytes
`include "eth_tx_params.svh"

module eth_frame_pad (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_data_t in_tdata,
    input  axis_pkg::axis_keep_t in_tkeep,
    input  logic                 in_tvalid,
    input  logic                 in_tlast,
    input  logic                 in_tuser,
    output logic                 in_tready,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep,
    output logic                 out_tvalid,
    output logic                 out_tlast,
    output logic                 out_tuser,
    input  logic                 out_tready
);

    localparam eth_pkg::byte_count_t MIN_BYTES  = `ETH_MIN_BYTES;
    localparam eth_pkg::byte_count_t WORD_BYTES = `ETH_KEEP_W;
    // first byte of the word that holds the last required byte
    localparam eth_pkg::byte_count_t TAIL_START =
        `ETH_MIN_BYTES - (`ETH_MIN_BYTES % `ETH_KEEP_W);
    localparam axis_pkg::axis_keep_t TAIL_KEEP =
        axis_pkg::axis_keep_t'((1 << (`ETH_MIN_BYTES % `ETH_KEEP_W)) - 1);

    eth_pkg::pad_state_t  state;
    eth_pkg::pad_state_t  state_next;
    eth_pkg::byte_count_t count;
    eth_pkg::byte_count_t count_next;
    eth_pkg::byte_count_t lane_count;
    axis_pkg::axis_data_t masked_tdata;
    logic                 short_last;
    logic                 at_tail;
    logic                 enter_fill;
    logic                 saved_tuser;

    always_comb begin
        lane_count = '0;
        for (int i = 0; i < `ETH_KEEP_W; i++) begin
            lane_count = lane_count + eth_pkg::byte_count_t'(in_tkeep[i]);
        end
    end

    // bytes outside keep go out as zero
    always_comb begin
        for (int i = 0; i < `ETH_KEEP_W; i++) begin
            masked_tdata[8*i +: 8] = in_tkeep[i] ? in_tdata[8*i +: 8] : 8'h00;
        end
    end

    assign short_last = in_tlast && (count + lane_count < MIN_BYTES);
    assign at_tail    = count >= TAIL_START;

    always_comb begin
        state_next = state;
        count_next = count;
        enter_fill = 1'b0;
        in_tready  = 1'b0;
        out_tdata  = '0;
        out_tkeep  = '0;
        out_tvalid = 1'b0;
        out_tlast  = 1'b0;
        out_tuser  = 1'b0;

        case (state)
            eth_pkg::pass: begin
                in_tready  = out_tready;
                out_tdata  = masked_tdata;
                out_tkeep  = in_tkeep;
                out_tvalid = in_tvalid;
                out_tlast  = in_tlast;
                out_tuser  = in_tuser && in_tlast;
                if (short_last) begin
                    if (at_tail) begin
                        // short word already covers byte 60
                        out_tkeep = TAIL_KEEP;
                    end else begin
                        out_tkeep = '1;
                        out_tlast = 1'b0;
                        out_tuser = 1'b0;
                    end
                end
                if (in_tvalid && out_tready) begin
                    if (short_last && !at_tail) begin
                        enter_fill = 1'b1;
                        count_next = count + WORD_BYTES;
                        state_next = eth_pkg::fill;
                    end else if (in_tlast) begin
                        count_next = '0;
                    end else if (count < MIN_BYTES) begin
                        count_next = count + WORD_BYTES;
                    end
                end
            end
            eth_pkg::fill: begin
                out_tvalid = 1'b1;
                out_tkeep  = at_tail ? TAIL_KEEP : '1;
                out_tlast  = at_tail;
                out_tuser  = at_tail && saved_tuser;
                if (out_tready) begin
                    if (at_tail) begin
                        count_next = '0;
                        state_next = eth_pkg::pass;
                    end else begin
                        count_next = count + WORD_BYTES;
                    end
                end
            end
            default: state_next = eth_pkg::pass;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= eth_pkg::pass;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    // error flag rides on the final fill word
    always_ff @(posedge clk) begin
        if (enter_fill) begin
            saved_tuser <= in_tuser;
        end
    end

endmodule

/* hdl/eth_tx_top.sv */
// Ethernet transmit top level: framer followed by the minimum-length padder
module eth_tx_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hdr_valid,
    output logic                 hdr_ready,
    input  eth_pkg::mac_addr_t   dest_mac,
    input  eth_pkg::mac_addr_t   src_mac,
    input  eth_pkg::ethertype_t  eth_type,
    input  axis_pkg::axis_data_t payload_tdata,
    input  axis_pkg::axis_keep_t payload_tkeep,
    input  logic                 payload_tvalid,
    output logic                 payload_tready,
    input  logic                 payload_tlast,
    input  logic                 payload_tuser,
    output axis_pkg::axis_data_t tx_tdata,
    output axis_pkg::axis_keep_t tx_tkeep,
    output logic                 tx_tvalid,
    input  logic                 tx_tready,
    output logic                 tx_tlast,
    output logic                 tx_tuser,
    output logic                 busy
);

    // framed stream before padding
    axis_pkg::axis_data_t mid_tdata;
    axis_pkg::axis_keep_t mid_tkeep;
    logic                 mid_tvalid;
    logic                 mid_tready;
    logic                 mid_tlast;
    logic                 mid_tuser;

    eth_axis_tx i_eth_axis_tx (
        .clk            (clk),
        .rst            (rst),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .dest_mac       (dest_mac),
        .src_mac        (src_mac),
        .eth_type       (eth_type),
        .payload_tdata  (payload_tdata),
        .payload_tkeep  (payload_tkeep),
        .payload_tvalid (payload_tvalid),
        .payload_tlast  (payload_tlast),
        .payload_tuser  (payload_tuser),
        .payload_tready (payload_tready),
        .out_tdata      (mid_tdata),
        .out_tkeep      (mid_tkeep),
        .out_tvalid     (mid_tvalid),
        .out_tlast      (mid_tlast),
        .out_tuser      (mid_tuser),
        .out_tready     (mid_tready),
        .busy           (busy)
    );

    eth_frame_pad i_eth_frame_pad (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (mid_tdata),
        .in_tkeep   (mid_tkeep),
        .in_tvalid  (mid_tvalid),
        .in_tlast   (mid_tlast),
        .in_tuser   (mid_tuser),
        .in_tready  (mid_tready),
        .out_tdata  (tx_tdata),
        .out_tkeep  (tx_tkeep),
        .out_tvalid (tx_tvalid),
        .out_tlast  (tx_tlast),
        .out_tuser  (tx_tuser),
        .out_tready (tx_tready)
    );

endmodule

/* verif/eth_tx_tb.sv */
// eth_tx testbench checking table-driven frames against a byte-level reference model
`include "eth_tx_params.svh"

module eth_tx_tb;

    localparam int NUM_TESTS   = 15;
    localparam int STALL_NONE  = 0;
    localparam int STALL_GAPS  = 1;
    localparam int STALL_READY = 2;

    logic                 clk;
    logic                 rst;
    logic                 hdr_valid;
    logic                 hdr_ready;
    eth_pkg::mac_addr_t   dest_mac;
    eth_pkg::mac_addr_t   src_mac;
    eth_pkg::ethertype_t  eth_type;
    axis_pkg::axis_data_t payload_tdata;
    axis_pkg::axis_keep_t payload_tkeep;
    logic                 payload_tvalid;
    logic                 payload_tready;
    logic                 payload_tlast;
    logic                 payload_tuser;
    axis_pkg::axis_data_t tx_tdata;
    axis_pkg::axis_keep_t tx_tkeep;
    logic                 tx_tvalid;
    logic                 tx_tready;
    logic                 tx_tlast;
    logic                 tx_tuser;
    logic                 busy;

    // stimulus table with one slot per frame
    string               names[NUM_TESTS];
    eth_pkg::mac_addr_t  t_dest[NUM_TESTS];
    eth_pkg::mac_addr_t  t_src[NUM_TESTS];
    eth_pkg::ethertype_t t_type[NUM_TESTS];
    int                  t_len[NUM_TESTS];
    logic                t_user[NUM_TESTS];
    int                  t_stall[NUM_TESTS];
    int                  num_entries;

    logic [7:0] exp_bytes[$];
    logic [7:0] got_bytes[$];
    integer     seed;
    int         cycle_limit;

    eth_tx_top i_eth_tx_top (
        .clk            (clk),
        .rst            (rst),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .dest_mac       (dest_mac),
        .src_mac        (src_mac),
        .eth_type       (eth_type),
        .payload_tdata  (payload_tdata),
        .payload_tkeep  (payload_tkeep),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .payload_tuser  (payload_tuser),
        .tx_tdata       (tx_tdata),
        .tx_tkeep       (tx_tkeep),
        .tx_tvalid      (tx_tvalid),
        .tx_tready      (tx_tready),
        .tx_tlast       (tx_tlast),
        .tx_tuser       (tx_tuser),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_entry(input string name, input eth_pkg::mac_addr_t dst,
                             input eth_pkg::mac_addr_t src, input eth_pkg::ethertype_t etype,
                             input int len, input logic user, input int stall);
        names[num_entries]   = name;
        t_dest[num_entries]  = dst;
        t_src[num_entries]   = src;
        t_type[num_entries]  = etype;
        t_len[num_entries]   = len;
        t_user[num_entries]  = user;
        t_stall[num_entries] = stall;
        num_entries++;
    endtask

    task automatic fill_table();
        add_entry("hdr_order_50", 48'h0a1b2c3d4e5f, 48'h021122334455, 16'h0800, 50, 0, STALL_NONE);
        add_entry("hdr_order_100", 48'hf0e1d2c3b4a5, 48'h02aabbccddee, 16'h86dd, 100, 0,
                  STALL_NONE);
        // last payload word holds 1, 2, 3, 6 and 8 bytes
        add_entry("tail_1", 48'h101112131415, 48'h202122232425, 16'h88b5, 65, 1, STALL_NONE);
        add_entry("tail_2", 48'h111213141516, 48'h212223242526, 16'h88b6, 66, 0, STALL_NONE);
        add_entry("tail_3", 48'h121314151617, 48'h222324252627, 16'h88b7, 67, 1, STALL_NONE);
        add_entry("tail_6", 48'h131415161718, 48'h232425262728, 16'h0806, 70, 0, STALL_NONE);
        add_entry("tail_8", 48'h141516171819, 48'h242526272829, 16'h0800, 72, 1, STALL_NONE);
        // short frames
        add_entry("pad_1", 48'hffffffffffff, 48'h020000000001, 16'h0806, 1, 1, STALL_NONE);
        add_entry("pad_20", 48'h010203040506, 48'h0a0b0c0d0e0f, 16'h0800, 20, 0, STALL_NONE);
        add_entry("pad_46", 48'h665544332211, 48'h0c0d0e0f1011, 16'h0800, 46, 1, STALL_NONE);
        add_entry("pad_47", 48'h778899aabbcc, 48'h123456789abc, 16'h0800, 47, 0, STALL_NONE);
        add_entry("gaps_90", 48'h3a3b3c3d3e3f, 48'h4a4b4c4d4e4f, 16'h86dd, 90, 1, STALL_GAPS);
        add_entry("gaps_5", 48'h5a5b5c5d5e5f, 48'h6a6b6c6d6e6f, 16'h0800, 5, 0, STALL_GAPS);
        add_entry("ready_123", 48'h7a7b7c7d7e7f, 48'h8a8b8c8d8e8f, 16'h0800, 123, 0,
                  STALL_READY);
        add_entry("ready_33", 48'h9a9b9c9d9e9f, 48'hcacbcccdcecf, 16'h88b5, 33, 1, STALL_READY);
    endtask

    function automatic int output_words(input int idx);
        int total;
        total = `ETH_HDR_BYTES + t_len[idx];
        if (total < `ETH_MIN_BYTES) begin
            total = `ETH_MIN_BYTES;
        end
        return (total + 7) / 8;
    endfunction

    // big-endian header followed by payload and zero padding up to the minimum
    task automatic build_expected(input int idx);
        int k;
        exp_bytes.delete();
        for (k = 0; k < 6; k++) begin
            exp_bytes.push_back(t_dest[idx][8*(5-k) +: 8]);
        end
        for (k = 0; k < 6; k++) begin
            exp_bytes.push_back(t_src[idx][8*(5-k) +: 8]);
        end
        exp_bytes.push_back(t_type[idx][15:8]);
        exp_bytes.push_back(t_type[idx][7:0]);
        for (k = 0; k < t_len[idx]; k++) begin
            exp_bytes.push_back((k + idx) & 8'hff);
        end
        while (exp_bytes.size() < `ETH_MIN_BYTES) begin
            exp_bytes.push_back(8'h00);
        end
    endtask

    task automatic check_value(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", label, expected, actual);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // hdr_valid stays high from the first header to the last one
    task automatic send_headers();
        int idx;
        for (idx = 0; idx < num_entries; idx++) begin
            @(negedge clk);
            dest_mac  = t_dest[idx];
            src_mac   = t_src[idx];
            eth_type  = t_type[idx];
            hdr_valid = 1'b1;
            @(posedge clk);
            while (!hdr_ready) @(posedge clk);
            // framer busy from the cycle after acceptance
            @(negedge clk);
            check_value($sformatf("%s busy", names[idx]), 1, busy);
        end
        hdr_valid = 1'b0;
    endtask

    task automatic send_payloads();
        int idx;
        int pos;
        int lane;
        for (idx = 0; idx < num_entries; idx++) begin
            for (pos = 0; pos < t_len[idx]; pos += 8) begin
                if (t_stall[idx] == STALL_GAPS) begin
                    while ($random(seed) & 1) begin
                        @(negedge clk);
                        payload_tvalid = 1'b0;
                    end
                end
                @(negedge clk);
                for (lane = 0; lane < 8; lane++) begin
                    // unused lanes carry junk that must never reach the output
                    if (pos + lane < t_len[idx]) begin
                        payload_tdata[8*lane +: 8] = (pos + lane + idx) & 8'hff;
                        payload_tkeep[lane]        = 1'b1;
                    end else begin
                        payload_tdata[8*lane +: 8] = 8'hee;
                        payload_tkeep[lane]        = 1'b0;
                    end
                end
                payload_tlast  = (pos + 8 >= t_len[idx]);
                payload_tuser  = payload_tlast && t_user[idx];
                payload_tvalid = 1'b1;
                @(posedge clk);
                while (!payload_tready) @(posedge clk);
            end
        end
        @(negedge clk);
        payload_tvalid = 1'b0;
        payload_tlast  = 1'b0;
    endtask

    // stream monitor and frame checker
    task automatic collect_frames();
        int                   idx;
        int                   k;
        int                   rem;
        logic                 done;
        axis_pkg::axis_keep_t last_keep;
        for (idx = 0; idx < num_entries; idx++) begin
            build_expected(idx);
            got_bytes.delete();
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                if (t_stall[idx] == STALL_READY) begin
                    tx_tready = $random(seed) & 1;
                end else begin
                    tx_tready = 1'b1;
                end
                @(posedge clk);
                if (tx_tvalid && tx_tready) begin
                    for (k = 0; k < 8; k++) begin
                        if (tx_tkeep[k]) begin
                            got_bytes.push_back(tx_tdata[8*k +: 8]);
                        end else begin
                            check_value($sformatf("%s idle lane %0d", names[idx], k), 0,
                                        tx_tdata[8*k +: 8]);
                        end
                    end
                    if (tx_tlast) begin
                        done      = 1'b1;
                        rem       = exp_bytes.size() % 8;
                        last_keep = (rem == 0) ? 8'hff : (8'hff >> (8 - rem));
                        check_value($sformatf("%s last keep", names[idx]), last_keep, tx_tkeep);
                        check_value($sformatf("%s tuser", names[idx]), t_user[idx], tx_tuser);
                    end else begin
                        check_value($sformatf("%s keep", names[idx]), 8'hff, tx_tkeep);
                        check_value($sformatf("%s early tuser", names[idx]), 0, tx_tuser);
                    end
                end
            end
            check_value($sformatf("%s byte count", names[idx]), exp_bytes.size(),
                        got_bytes.size());
            for (k = 0; k < exp_bytes.size(); k++) begin
                check_value($sformatf("%s byte %0d", names[idx], k), exp_bytes[k],
                            got_bytes[k]);
            end
        end
        @(negedge clk);
        tx_tready = 1'b1;
    endtask

    task automatic watch_cycles();
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: output stalled, frames incomplete after %0d cycles", cycle_limit);
        $display("test failed");
        $fatal(1, "simulation stopped on timeout");
    endtask

    initial begin
        int idx;
        seed           = 73;
        num_entries    = 0;
        rst            = 1'b1;
        hdr_valid      = 1'b0;
        dest_mac       = '0;
        src_mac        = '0;
        eth_type       = '0;
        payload_tdata  = '0;
        payload_tkeep  = '0;
        payload_tvalid = 1'b0;
        payload_tlast  = 1'b0;
        payload_tuser  = 1'b0;
        tx_tready      = 1'b1;
        fill_table();
        cycle_limit = 200;
        for (idx = 0; idx < num_entries; idx++) begin
            cycle_limit += 4 * output_words(idx);
        end
        fork
            watch_cycles();
        join_none

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("reset hdr_ready", 0, hdr_ready);
        check_value("reset payload_tready", 0, payload_tready);
        check_value("reset tx_tvalid", 0, tx_tvalid);
        check_value("reset busy", 0, busy);
        rst = 1'b0;
        @(negedge clk);
        check_value("hdr_ready after reset", 1, hdr_ready);
        check_value("busy after reset", 0, busy);

        fork
            send_headers();
            send_payloads();
            collect_frames();
        join

        // framer idle and stream empty once the last frame has left
        repeat (4) begin
            @(negedge clk);
            check_value("busy at end", 0, busy);
            check_value("tx_tvalid at end", 0, tx_tvalid);
            check_value("hdr_ready at end", 1, hdr_ready);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* eth_tx.f */
+incdir+hdl
hdl/eth_pkg.sv
hdl/axis_pkg.sv
hdl/axis_out_buffer.sv
hdl/eth_axis_tx.sv
hdl/eth_frame_pad.sv
hdl/eth_tx_top.sv
verif/eth_tx_tb.sv
